/* Makefile */
TOP = cardio_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* flist.f */
+incdir+hw
+incdir+verification
hw/cardio_pkg.sv
hw/feature_loader.sv
hw/argmax.sv
hw/cardio_tp.sv
hw/class_tally.sv
hw/cardio_classifier_top.sv
verification/cardio_tb.sv

/* hw/argmax.sv */
`include "cardio_settings.svh"

module argmax (
    input  cardio_pkg::score_t [`CLASS_CNT-1:0] scores,
    output cardio_pkg::class_e                  index
);
    import cardio_pkg::*;

    score_t                    best;
    logic [$bits(class_e)-1:0] best_idx;

    // strict greater-than keeps the first maximum, so ties go to the lower class.
    always_comb begin
        best     = scores[0];
        best_idx = '0;
        for (int c = 1; c < `CLASS_CNT; c++) begin
            if (scores[c] > best) begin
                best     = scores[c];
                best_idx = $bits(class_e)'(c);
            end
        end
    end

    assign index = class_e'(best_idx);

    always_comb begin
        index_in_range: assert (int'(index) < `CLASS_CNT)
            else $error("argmax index %0d is not a class.", index);
    end

endmodule

/* hw/cardio_classifier_top.sv */
module cardio_classifier_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 feature_valid,
    input  logic                 frame_start,
    input  logic                 tally_clear,
    input  cardio_pkg::feature_t feature_data,
    input  cardio_pkg::class_e   tally_sel,
    output logic                 result_valid,
    output cardio_pkg::class_e   result_class,
    output cardio_pkg::tally_t   tally_count
);
    import cardio_pkg::*;

    sample_t sample;
    logic    sample_ready;
    class_e  prediction;

    feature_loader u_loader (
        .clk           (clk),
        .rst_n         (rst_n),
        .feature_valid (feature_valid),
        .frame_start   (frame_start),
        .feature_data  (feature_data),
        .sample        (sample),
        .sample_ready  (sample_ready)
    );

    // the network is purely combinational on the packed sample.
    cardio_tp u_network (
        .sample     (sample),
        .prediction (prediction)
    );

    // Result stage. The loader may already be shifting in the next sample, but the
    // sample vector only moves on a feature strobe, so prediction is still the
    // finished sample's class while sample_ready is high.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result_class <= CLASS_NORMAL;
        end else begin
            result_valid <= sample_ready;
            if (sample_ready) begin
                result_class <= prediction; // held until the next sample completes.
            end
        end
    end

    class_tally u_tally (
        .clk         (clk),
        .rst_n       (rst_n),
        .count_en    (result_valid),
        .count_class (result_class),
        .clear       (tally_clear),
        .sel         (tally_sel),
        .count       (tally_count)
    );

endmodule

/* hw/cardio_pkg.sv */
`include "cardio_settings.svh"

package cardio_pkg;

    // a score is twice a popcount over the hidden layer, so one extra bit.
    localparam int SCORE_BITS = $clog2(`HIDDEN_CNT + 1) + 1;

    typedef logic [`FEAT_BITS-1:0] feature_t;

    // feature 0 lives in the top nibble.
    typedef logic [`FEAT_CNT*`FEAT_BITS-1:0] sample_t;

    typedef logic [SCORE_BITS-1:0] score_t;

    typedef logic [`TALLY_BITS-1:0] tally_t;

    typedef enum logic [1:0] {
        CLASS_NORMAL     = 2'd0,
        CLASS_SUSPECT    = 2'd1,
        CLASS_PATHOLOGIC = 2'd2
    } class_e;

    typedef enum logic {
        LOAD_IDLE,   // no partial sample held.
        LOAD_COLLECT // at least one feature of the sample is in.
    } load_state_e;

endpackage

/* hw/cardio_settings.svh */
`ifndef CARDIO_SETTINGS_SVH
`define CARDIO_SETTINGS_SVH

// features per sample, streamed one nibble at a time.
`define FEAT_CNT 19

`define FEAT_BITS 4 // width of one feature.

// hidden layer size of the fixed ternary network.
`define HIDDEN_CNT 40

`define CLASS_CNT 3 // normal, suspect, pathologic.

// per-class result counters saturate at all ones.
`define TALLY_BITS 16

`endif

/* hw/cardio_tp.sv */
`include "cardio_settings.svh"

module cardio_tp (
    input  cardio_pkg::sample_t sample,
    output cardio_pkg::class_e  prediction
);
    import cardio_pkg::*;

    localparam int SUM_BITS = $clog2(`HIDDEN_CNT + 1);
    localparam int ACC_BITS = $clog2(`FEAT_CNT + 1) + `FEAT_BITS;

    // bit j of a mask selects feature j into the sum.
    localparam logic [`FEAT_CNT-1:0] POS_MASK [`HIDDEN_CNT] = '{
        19'h44036, 19'h31004, 19'h1011B, 19'h20301, 19'h24405,
        19'h21251, 19'h20240, 19'h42211, 19'h22000, 19'h40211,
        19'h01290, 19'h00B50, 19'h50244, 19'h2E00A, 19'h00580,
        19'h01400, 19'h05060, 19'h0012A, 19'h1442A, 19'h40314,
        19'h029A6, 19'h0D208, 19'h20002, 19'h08800, 19'h1048B,
        19'h00108, 19'h1880A, 19'h05722, 19'h28022, 19'h02000,
        19'h00B4E, 19'h45BB2, 19'h0C0AA, 19'h06821, 19'h04023,
        19'h68001, 19'h201AA, 19'h4008A, 19'h4C260, 19'h411E1
    };

    localparam logic [`FEAT_CNT-1:0] NEG_MASK [`HIDDEN_CNT] = '{
        19'h20000, 19'h020A2, 19'h05804, 19'h0A0AA, 19'h1B112,
        19'h0892A, 19'h1C00B, 19'h0948A, 19'h44640, 19'h041AA,
        19'h48D0A, 19'h0C002, 19'h0800A, 19'h40655, 19'h00040,
        19'h08BAE, 19'h20A8A, 19'h012C0, 19'h00140, 19'h324CA,
        19'h04640, 19'h10023, 19'h000A0, 19'h04135, 19'h01240,
        19'h41401, 19'h40680, 19'h02090, 19'h04211, 19'h7D011,
        19'h2A011, 19'h3A40C, 19'h40244, 19'h61216, 19'h02088,
        19'h11824, 19'h00610, 19'h20614, 19'h3008A, 19'h2400A
    };

    // neurons that feed each class popcount.
    localparam logic [`HIDDEN_CNT-1:0] CLASS_USE [`CLASS_CNT] = '{
        40'h331D02140A,
        40'h22580092E6,
        40'h428808A9B4
    };

    // neurons that enter the popcount inverted.
    localparam logic [`HIDDEN_CNT-1:0] CLASS_INV [`CLASS_CNT] = '{
        40'h0200001408,
        40'h2240000004,
        40'h020000A100
    };

    logic [`HIDDEN_CNT-1:0]       hidden;
    logic [SUM_BITS-1:0]          popcount [`CLASS_CNT];
    score_t [`CLASS_CNT-1:0]      scores;

    // Sums the features picked by mask. The worst case is all features at 15,
    // which still fits in ACC_BITS.
    function automatic logic [ACC_BITS-1:0] masked_sum(
        input sample_t                s,
        input logic [`FEAT_CNT-1:0]   mask
    );
        logic [ACC_BITS-1:0] acc;
        acc = '0;
        for (int j = 0; j < `FEAT_CNT; j++) begin
            if (mask[j]) begin
                acc = acc + ACC_BITS'(s[(`FEAT_CNT-1-j)*`FEAT_BITS +: `FEAT_BITS]);
            end
        end
        return acc;
    endfunction

    // each neuron fires when its positive inputs outweigh or tie its negative ones.
    for (genvar n = 0; n < `HIDDEN_CNT; n++) begin : g_neuron
        assign hidden[n] = masked_sum(sample, POS_MASK[n]) >= masked_sum(sample, NEG_MASK[n]);
    end

    for (genvar c = 0; c < `CLASS_CNT; c++) begin : g_class
        assign popcount[c] = SUM_BITS'($countones((hidden ^ CLASS_INV[c]) & CLASS_USE[c]));
        assign scores[c]   = {popcount[c], 1'b0}; // score is twice the popcount.
    end

    argmax u_argmax (
        .scores (scores),
        .index  (prediction)
    );

endmodule

/* hw/class_tally.sv */
`include "cardio_settings.svh"

module class_tally (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               count_en,
    input  cardio_pkg::class_e count_class,
    input  logic               clear,
    input  cardio_pkg::class_e sel,
    output cardio_pkg::tally_t count
);
    import cardio_pkg::*;

    tally_t counters [`CLASS_CNT];

    for (genvar c = 0; c < `CLASS_CNT; c++) begin : g_counter
        logic hit;

        assign hit = count_en && (count_class == class_e'(c));

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                counters[c] <= '0;
            end else if (clear) begin
                counters[c] <= '0; // clear wins over a same-cycle result.
            end else if (hit && (counters[c] != '1)) begin
                counters[c] <= counters[c] + 1'b1;
            end
        end

        // once full, a counter stays full until the host clears it.
        no_wrap: assert property (
            @(posedge clk) disable iff (!rst_n)
            (counters[c] == '1) && !clear |=> (counters[c] == '1)
        ) else $error("class %0d tally left saturation without a clear.", c);
    end

    // select 3 is not a class and reads as zero.
    always_comb begin
        if (int'(sel) < `CLASS_CNT) begin
            count = counters[sel];
        end else begin
            count = '0;
        end
    end

endmodule

/* hw/feature_loader.sv */
`include "cardio_settings.svh"

module feature_loader (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 feature_valid,
    input  logic                 frame_start,
    input  cardio_pkg::feature_t feature_data,
    output cardio_pkg::sample_t  sample,
    output logic                 sample_ready
);
    import cardio_pkg::*;

    localparam int CNT_BITS = $clog2(`FEAT_CNT);

    load_state_e         state;
    logic [CNT_BITS-1:0] feat_cnt;
    logic [CNT_BITS-1:0] feat_idx;
    logic                first_feat;
    logic                last_feat;

    // a frame start or an idle loader means the incoming feature is feature 0.
    assign first_feat = frame_start || (state == LOAD_IDLE);
    assign feat_idx   = first_feat ? '0 : feat_cnt;
    assign last_feat  = feature_valid && (feat_idx == CNT_BITS'(`FEAT_CNT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= LOAD_IDLE;
            feat_cnt     <= '0;
            sample_ready <= 1'b0;
        end else begin
            sample_ready <= last_feat;
            if (feature_valid) begin
                if (last_feat) begin
                    state    <= LOAD_IDLE;
                    feat_cnt <= '0;
                end else begin
                    state    <= LOAD_COLLECT;
                    feat_cnt <= feat_idx + 1'b1;
                end
            end else if (frame_start) begin
                state    <= LOAD_IDLE; // partial sample is dropped.
                feat_cnt <= '0;
            end
        end
    end

    // The shift register is the sample itself. After FEAT_CNT shifts feature 0 has
    // reached the top nibble and the older, discarded features are gone.
    always_ff @(posedge clk) begin
        if (feature_valid) begin
            sample <= {sample[$bits(sample_t)-`FEAT_BITS-1:0], feature_data};
        end
    end

    // a full sample takes FEAT_CNT strobes, so ready can never repeat back to back.
    ready_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) sample_ready |=> !sample_ready
    ) else $error("sample_ready held high for two cycles.");

endmodule

/* verification/cardio_weights.svh */
`ifndef CARDIO_WEIGHTS_SVH
`define CARDIO_WEIGHTS_SVH

// bit j of a feature mask picks feature j, bit n of a class mask picks neuron n.
localparam logic [`FEAT_CNT-1:0] W_POS [`HIDDEN_CNT] = '{
    19'h44036, 19'h31004, 19'h1011B, 19'h20301, 19'h24405,
    19'h21251, 19'h20240, 19'h42211, 19'h22000, 19'h40211,
    19'h01290, 19'h00B50, 19'h50244, 19'h2E00A, 19'h00580,
    19'h01400, 19'h05060, 19'h0012A, 19'h1442A, 19'h40314,
    19'h029A6, 19'h0D208, 19'h20002, 19'h08800, 19'h1048B,
    19'h00108, 19'h1880A, 19'h05722, 19'h28022, 19'h02000,
    19'h00B4E, 19'h45BB2, 19'h0C0AA, 19'h06821, 19'h04023,
    19'h68001, 19'h201AA, 19'h4008A, 19'h4C260, 19'h411E1
};

localparam logic [`FEAT_CNT-1:0] W_NEG [`HIDDEN_CNT] = '{
    19'h20000, 19'h020A2, 19'h05804, 19'h0A0AA, 19'h1B112,
    19'h0892A, 19'h1C00B, 19'h0948A, 19'h44640, 19'h041AA,
    19'h48D0A, 19'h0C002, 19'h0800A, 19'h40655, 19'h00040,
    19'h08BAE, 19'h20A8A, 19'h012C0, 19'h00140, 19'h324CA,
    19'h04640, 19'h10023, 19'h000A0, 19'h04135, 19'h01240,
    19'h41401, 19'h40680, 19'h02090, 19'h04211, 19'h7D011,
    19'h2A011, 19'h3A40C, 19'h40244, 19'h61216, 19'h02088,
    19'h11824, 19'h00610, 19'h20614, 19'h3008A, 19'h2400A
};

localparam logic [`HIDDEN_CNT-1:0] W_USE [`CLASS_CNT] = '{
    40'h331D02140A, 40'h22580092E6, 40'h428808A9B4
};

localparam logic [`HIDDEN_CNT-1:0] W_INV [`CLASS_CNT] = '{
    40'h0200001408, 40'h2240000004, 40'h020000A100
};

// expected class of one sample, given as separate features.
function automatic class_e ref_class(input feature_t feat [`FEAT_CNT]);
    int                     pos_sum;
    int                     neg_sum;
    int                     votes;
    int                     score;
    int                     best_score;
    int                     best_idx;
    logic [`HIDDEN_CNT-1:0] fired;
    for (int n = 0; n < `HIDDEN_CNT; n++) begin
        pos_sum = 0;
        neg_sum = 0;
        for (int j = 0; j < `FEAT_CNT; j++) begin
            if (W_POS[n][j]) pos_sum += int'(feat[j]);
            if (W_NEG[n][j]) neg_sum += int'(feat[j]);
        end
        fired[n] = (pos_sum >= neg_sum); // a tie still fires.
    end
    best_score = -1;
    best_idx   = 0;
    for (int c = 0; c < `CLASS_CNT; c++) begin
        votes = 0;
        for (int n = 0; n < `HIDDEN_CNT; n++) begin
            if (W_USE[c][n] && (fired[n] != W_INV[c][n])) votes++;
        end
        score = 2 * votes;
        if (score > best_score) begin // first maximum wins.
            best_score = score;
            best_idx   = c;
        end
    end
    return class_e'(2'(best_idx));
endfunction

`endif

/* verification/cardio_tb.sv */
`include "cardio_settings.svh"

module cardio_tb;
    import cardio_pkg::*;
    `include "cardio_weights.svh"

    localparam int RESULT_TIMEOUT = 100;
    localparam int RANDOM_SAMPLES = 300;
    // edges from driving the last feature to seeing result_valid.
    localparam int RESULT_DELAY   = 3;

    logic     clk;
    logic     rst_n;
    logic     feature_valid;
    logic     frame_start;
    logic     tally_clear;
    feature_t feature_data;
    class_e   tally_sel;
    logic     result_valid;
    class_e   result_class;
    tally_t   tally_count;

    class_e   exp_class_q [$];
    int       exp_cycle_q [$];
    tally_t   exp_tally [`CLASS_CNT];
    feature_t cur_feat [`FEAT_CNT];
    int       cycle_cnt;
    int       check_cnt;
    int       error_cnt;
    int       test_cnt;
    int       test_errors;

    cardio_classifier_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .feature_valid (feature_valid),
        .frame_start   (frame_start),
        .tally_clear   (tally_clear),
        .feature_data  (feature_data),
        .tally_sel     (tally_sel),
        .result_valid  (result_valid),
        .result_class  (result_class),
        .tally_count   (tally_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic compare_class(input string name, input class_e got, input class_e exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compare_tally(input string name, input tally_t got, input tally_t exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic fill_random();
        for (int j = 0; j < `FEAT_CNT; j++) cur_feat[j] = feature_t'($urandom_range(15, 0));
    endtask

    task automatic fill_constant(input feature_t value);
        for (int j = 0; j < `FEAT_CNT; j++) cur_feat[j] = value;
    endtask

    // streams cur_feat with no gaps and queues the reference result.
    task automatic stream_sample(input logic restart);
        class_e cls;
        for (int j = 0; j < `FEAT_CNT; j++) begin
            @(posedge clk);
            feature_valid <= 1'b1;
            feature_data  <= cur_feat[j];
            frame_start   <= restart && (j == 0);
        end
        cls = ref_class(cur_feat);
        exp_class_q.push_back(cls);
        exp_cycle_q.push_back(cycle_cnt);
        if (exp_tally[int'(cls)] != '1) exp_tally[int'(cls)]++;
    endtask

    task automatic stream_partial(input int count);
        for (int j = 0; j < count; j++) begin
            @(posedge clk);
            feature_valid <= 1'b1;
            feature_data  <= feature_t'($urandom_range(15, 0));
            frame_start   <= 1'b0;
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        feature_valid <= 1'b0;
        frame_start   <= 1'b0;
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_class_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > RESULT_TIMEOUT * 4) begin
                abort_run("results still pending after streaming stopped");
            end
        end
        repeat (2) @(posedge clk); // let the last result reach its counter.
    endtask

    task automatic check_all_tallies();
        for (int c = 0; c < `CLASS_CNT; c++) begin
            @(posedge clk);
            tally_sel <= class_e'(2'(c));
            @(posedge clk);
            compare_tally($sformatf("tally_count[%0d]", c), tally_count, exp_tally[c]);
        end
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("test %0d %s: %0d errors", test_cnt, name, error_cnt - test_errors);
        test_errors = error_cnt;
    endtask

    // Each result is popped in order. A result with nothing queued means the DUT
    // produced one sample too many.
    initial begin : compare_results
        int     wait_cnt;
        int     drive_cyc;
        class_e exp_cls;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            if (result_valid === 1'b1) begin
                wait_cnt = 0;
                if (exp_class_q.size() == 0) begin
                    error_cnt++;
                    $display("result_valid pulsed with no sample pending.");
                end else begin
                    exp_cls   = exp_class_q.pop_front();
                    drive_cyc = exp_cycle_q.pop_front();
                    compare_class("result_class", result_class, exp_cls);
                    check_cnt++;
                    if (cycle_cnt - drive_cyc != RESULT_DELAY) begin
                        error_cnt++;
                        $display("result_valid came %0d edges after the last feature, not %0d.",
                                 cycle_cnt - drive_cyc, RESULT_DELAY);
                    end
                end
            end else if (exp_class_q.size() != 0) begin
                wait_cnt++;
                if (wait_cnt > RESULT_TIMEOUT) abort_run("no result_valid for a finished sample");
            end else begin
                wait_cnt = 0;
            end
        end
    end

    initial begin
        void'($urandom(32'hf39d));
        cycle_cnt     = 0;
        check_cnt     = 0;
        error_cnt     = 0;
        test_cnt      = 0;
        test_errors   = 0;
        rst_n         = 1'b0;
        feature_valid = 1'b0;
        frame_start   = 1'b0;
        tally_clear   = 1'b0;
        feature_data  = '0;
        tally_sel     = CLASS_NORMAL;
        for (int c = 0; c < `CLASS_CNT; c++) exp_tally[c] = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        fill_constant(4'h0); // every neuron fires on the all-zero sample.
        stream_sample(1'b0);
        fill_constant(4'hF);
        stream_sample(1'b0);
        go_idle();
        drain_results();
        finish_test("corner samples");

        for (int s = 0; s < RANDOM_SAMPLES; s++) begin
            fill_random();
            stream_sample(1'b0);
        end
        go_idle();
        drain_results();
        finish_test("random samples");

        // first a restart on its own, then one that arrives with feature 0.
        for (int r = 0; r < 2; r++) begin
            stream_partial($urandom_range(`FEAT_CNT - 1, 1));
            if (r == 0) begin
                @(posedge clk);
                feature_valid <= 1'b0;
                frame_start   <= 1'b1;
            end
            fill_random();
            stream_sample(r == 1);
            go_idle();
            drain_results();
            repeat (`FEAT_CNT) @(posedge clk);
        end
        finish_test("frame restart");

        check_all_tallies();
        finish_test("tally after run");

        @(posedge clk);
        tally_clear <= 1'b1;
        @(posedge clk);
        tally_clear <= 1'b0;
        for (int c = 0; c < `CLASS_CNT; c++) exp_tally[c] = '0;
        check_all_tallies();
        fill_random();
        stream_sample(1'b0);
        go_idle();
        drain_results();
        check_all_tallies();
        finish_test("tally clear");

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
